//--- verilog/vecu_pkg.sv
/*
 * Shared types and constants of the vecu vector coprocessor.
 * Elements are 32-bit integers and all arithmetic wraps modulo 2^32.
 * Opcode values outside vecu_op_e are illegal and get an error response.
 */
package vecu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VRegIdxWidth = $clog2(NrVRegs);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0]    elem_t;
  typedef logic [VRegIdxWidth-1:0] vreg_idx_t;

  // Kept instruction set, other 4-bit codes are illegal
  typedef enum logic [3:0] {
    VSPLAT  = 4'h0,
    VIDX    = 4'h1,
    VADD    = 4'h2,
    VSUB    = 4'h3,
    VAND    = 4'h4,
    VXOR    = 4'h5,
    VREDSUM = 4'h6
  } vecu_op_e;

  // Request from the scalar core
  typedef struct packed {
    vecu_op_e  op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } acc_req_t;

  // Response to the scalar core
  typedef struct packed {
    elem_t result;
    logic  error;
  } acc_resp_t;

endpackage : vecu_pkg

//--- verilog/vecu_fifo.sv
`timescale 1ns/1ps
/*
 * Synchronous FIFO with a type parameter for its payload.
 * A push while full and a pop while empty are ignored.
 * A pushed entry shows on data_o from the next cycle.
 */
module vecu_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // Pointer increment with wrap at Depth
  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(Depth));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule : vecu_fifo

//--- verilog/vecu_dispatcher.sv
`timescale 1ns/1ps
/*
 * Core-facing side of vecu: two-entry request and response queues.
 * The sequencer pops only while idle, so gating on a free response
 * slot is enough to keep the response push from meeting a full queue.
 */
module vecu_dispatcher (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Scalar core
  input  vecu_pkg::acc_req_t  acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output vecu_pkg::acc_resp_t acc_resp_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i,
  // Sequencer
  output vecu_pkg::acc_req_t  vecu_req_o,
  output logic                vecu_req_valid_o,
  output logic                vecu_req_illegal_o,
  input  logic                vecu_req_ready_i,
  input  vecu_pkg::acc_resp_t vecu_resp_i,
  input  logic                vecu_resp_valid_i
);

  localparam int unsigned QueueDepth = 2;

  logic req_empty;
  logic req_full;
  logic resp_empty;
  logic resp_full;

  assign acc_req_ready_o  = ~req_full;
  assign acc_resp_valid_o = ~resp_empty;

  vecu_fifo #(
    .payload_t(vecu_pkg::acc_req_t),
    .Depth    (QueueDepth         )
  ) i_req_queue (
    .clk_i  (clk_i                            ),
    .rst_n_i(rst_n_i                          ),
    .push_i (acc_req_valid_i & acc_req_ready_o),
    .data_i (acc_req_i                        ),
    .pop_i  (vecu_req_ready_i                 ),
    .data_o (vecu_req_o                       ),
    .empty_o(req_empty                        ),
    .full_o (req_full                         )
  );

  // Hold back the next instruction until its response has a slot
  assign vecu_req_valid_o   = ~req_empty & ~resp_full;
  assign vecu_req_illegal_o = !(vecu_req_o.op inside {vecu_pkg::VSPLAT, vecu_pkg::VIDX,
                                                      vecu_pkg::VADD, vecu_pkg::VSUB,
                                                      vecu_pkg::VAND, vecu_pkg::VXOR,
                                                      vecu_pkg::VREDSUM});

  vecu_fifo #(
    .payload_t(vecu_pkg::acc_resp_t),
    .Depth    (QueueDepth          )
  ) i_resp_queue (
    .clk_i  (clk_i                              ),
    .rst_n_i(rst_n_i                            ),
    .push_i (vecu_resp_valid_i                  ),
    .data_i (vecu_resp_i                        ),
    .pop_i  (acc_resp_valid_o & acc_resp_ready_i),
    .data_o (acc_resp_o                         ),
    .empty_o(resp_empty                         ),
    .full_o (resp_full                          )
  );

endmodule : vecu_dispatcher

//--- verilog/vecu_sequencer.sv
`timescale 1ns/1ps
/*
 * Runs one instruction at a time on all lanes.
 * The lane controls stay stable from the start pulse until the response.
 * Illegal instructions respond one cycle after the pop without a start.
 */
module vecu_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Dispatcher
  input  vecu_pkg::acc_req_t  vecu_req_i,
  input  logic                vecu_req_valid_i,
  input  logic                vecu_req_illegal_i,
  output logic                vecu_req_ready_o,
  output vecu_pkg::acc_resp_t vecu_resp_o,
  output logic                vecu_resp_valid_o,
  // Lanes
  output vecu_pkg::vecu_op_e  lane_op_o,
  output vecu_pkg::vreg_idx_t lane_vd_o,
  output vecu_pkg::vreg_idx_t lane_vs1_o,
  output vecu_pkg::vreg_idx_t lane_vs2_o,
  output vecu_pkg::elem_t     lane_scalar_o,
  output logic                lane_start_o,
  input  logic [NrLanes-1:0]  lane_done_i,
  // Reduction unit
  input  vecu_pkg::elem_t     red_sum_i,
  input  logic                red_valid_i
);

  typedef enum logic [1:0] {
    Idle,
    Run,
    WaitRed,
    Respond
  } state_e;

  state_e             state_q;
  state_e             state_d;
  logic               pop;
  logic               start_q;
  logic               illegal_q;
  logic [NrLanes-1:0] done_q;
  logic               all_done;
  vecu_pkg::acc_req_t insn_q;
  vecu_pkg::elem_t    result_q;

  assign pop              = (state_q == Idle) & vecu_req_valid_i;
  assign vecu_req_ready_o = pop;
  assign all_done         = &(done_q | lane_done_i);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (vecu_req_valid_i) state_d = vecu_req_illegal_i ? Respond : Run;
      end
      Run: begin
        if (all_done) state_d = (insn_q.op == vecu_pkg::VREDSUM) ? WaitRed : Respond;
      end
      WaitRed: begin
        if (red_valid_i) state_d = Respond;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      start_q <= 1'b0;
      done_q  <= '0;
    end else begin
      state_q <= state_d;
      start_q <= pop & ~vecu_req_illegal_i;
      // Done flags collected per lane
      if (pop) begin
        done_q <= '0;
      end else if (state_q == Run) begin
        done_q <= done_q | lane_done_i;
      end
    end
  end

  // Instruction and result registers
  always_ff @(posedge clk_i) begin
    if (pop) begin
      insn_q    <= vecu_req_i;
      illegal_q <= vecu_req_illegal_i;
      result_q  <= '0;
    end else if (state_q == WaitRed && red_valid_i) begin
      result_q <= red_sum_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign lane_op_o     = insn_q.op;
  assign lane_vd_o     = insn_q.vd;
  assign lane_vs1_o    = insn_q.vs1;
  assign lane_vs2_o    = insn_q.vs2;
  assign lane_scalar_o = insn_q.scalar;
  assign lane_start_o  = start_q;

  assign vecu_resp_valid_o  = (state_q == Respond);
  assign vecu_resp_o.result = result_q;
  assign vecu_resp_o.error  = illegal_q;

endmodule : vecu_sequencer

//--- verilog/vecu_lane.sv
`timescale 1ns/1ps
/*
 * One lane: its slice of the register file, the ALU and a partial sum.
 * Lane L holds global elements L, L+NrLanes, L+2*NrLanes and so on.
 * Element 0 is handled in the start cycle, done follows VecLen/NrLanes
 * cycles after start. Register contents are not reset.
 */
module vecu_lane #(
  parameter  int unsigned NrLanes = 4,
  parameter  int unsigned VecLen  = 16,
  localparam int unsigned LaneIdW = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [LaneIdW-1:0]  lane_id_i,
  input  vecu_pkg::vecu_op_e  lane_op_i,
  input  vecu_pkg::vreg_idx_t lane_vd_i,
  input  vecu_pkg::vreg_idx_t lane_vs1_i,
  input  vecu_pkg::vreg_idx_t lane_vs2_i,
  input  vecu_pkg::elem_t     lane_scalar_i,
  input  logic                lane_start_i,
  output logic                lane_done_o,
  output vecu_pkg::elem_t     lane_partial_o
);

  localparam int unsigned ElemsPerLane = VecLen / NrLanes;
  localparam int unsigned IdxW         = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;
  localparam int unsigned VrfDepth     = vecu_pkg::NrVRegs * ElemsPerLane;
  localparam int unsigned AddrW        = $clog2(VrfDepth);

  vecu_pkg::elem_t vrf_q [VrfDepth];
  logic            busy_q;
  logic            done_q;
  logic            active;
  logic            last;
  logic [IdxW-1:0] idx_q;
  logic [IdxW-1:0] cur_idx;
  vecu_pkg::elem_t opa;
  vecu_pkg::elem_t opb;
  vecu_pkg::elem_t result;
  vecu_pkg::elem_t elem_gidx;
  vecu_pkg::elem_t acc_q;

  // Register-major layout of the slice
  function automatic logic [AddrW-1:0] vrf_addr(vecu_pkg::vreg_idx_t vreg,
                                                logic [IdxW-1:0] idx);
    return AddrW'(vreg) * AddrW'(ElemsPerLane) + AddrW'(idx);
  endfunction

  assign active  = lane_start_i | busy_q;
  assign cur_idx = lane_start_i ? '0 : idx_q;
  assign last    = (cur_idx == IdxW'(ElemsPerLane - 1));
  assign opa     = vrf_q[vrf_addr(lane_vs1_i, cur_idx)];
  assign opb     = vrf_q[vrf_addr(lane_vs2_i, cur_idx)];

  // Index of the element within the whole vector
  assign elem_gidx = vecu_pkg::elem_t'(cur_idx) * vecu_pkg::elem_t'(NrLanes)
                   + vecu_pkg::elem_t'(lane_id_i);

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (lane_op_i)
      vecu_pkg::VSPLAT: result = lane_scalar_i;
      vecu_pkg::VIDX:   result = elem_gidx;
      vecu_pkg::VADD:   result = opa + opb;
      vecu_pkg::VSUB:   result = opa - opb;
      vecu_pkg::VAND:   result = opa & opb;
      vecu_pkg::VXOR:   result = opa ^ opb;
      default:          result = opa;
    endcase
  end

  // Element stepping
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      done_q <= active & last;
      if (active) begin
        busy_q <= ~last;
        idx_q  <= cur_idx + 1'b1;
      end
    end
  end

  // Write back or accumulate
  always_ff @(posedge clk_i) begin
    if (active) begin
      if (lane_op_i == vecu_pkg::VREDSUM) begin
        acc_q <= (lane_start_i ? '0 : acc_q) + opa;
      end else begin
        vrf_q[vrf_addr(lane_vd_i, cur_idx)] <= result;
      end
    end
  end

  assign lane_done_o    = done_q;
  assign lane_partial_o = acc_q;

endmodule : vecu_lane

//--- verilog/vecu_reduce.sv
`timescale 1ns/1ps
/*
 * Sums the lane partial results, wrapping modulo 2^32.
 * Each lane must keep its partial stable after its done pulse.
 * Valid pulses one cycle after the last lane reports done.
 */
module vecu_reduce #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  vecu_pkg::elem_t [NrLanes-1:0]     lane_partial_i,
  input  logic            [NrLanes-1:0]     lane_done_i,
  output vecu_pkg::elem_t                   red_sum_o,
  output logic                              red_valid_o
);

  logic [NrLanes-1:0] seen_q;
  logic [NrLanes-1:0] seen;
  logic               all_done;
  vecu_pkg::elem_t    sum;

  assign seen     = seen_q | lane_done_i;
  assign all_done = (&seen) & (|lane_done_i);

  // Adder tree over all lanes
  always_comb begin
    sum = '0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      sum = sum + lane_partial_i[l];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      seen_q      <= '0;
      red_valid_o <= 1'b0;
    end else begin
      red_valid_o <= all_done;
      seen_q      <= all_done ? '0 : seen;
    end
  end

  always_ff @(posedge clk_i) begin
    if (all_done) red_sum_o <= sum;
  end

endmodule : vecu_reduce

//--- verilog/vecu.sv
`timescale 1ns/1ps
/*
 * vecu top level, a vector coprocessor behind a valid/ready channel.
 * NrLanes and VecLen must be powers of two and VecLen >= NrLanes.
 * Register file contents are undefined after reset.
 */
module vecu #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VecLen  = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vecu_pkg::acc_req_t  acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output vecu_pkg::acc_resp_t acc_resp_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i
);

  localparam int unsigned LaneIdW = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  // Dispatcher to sequencer
  vecu_pkg::acc_req_t  vecu_req;
  logic                vecu_req_valid;
  logic                vecu_req_illegal;
  logic                vecu_req_ready;
  vecu_pkg::acc_resp_t vecu_resp;
  logic                vecu_resp_valid;
  // Sequencer to lanes
  vecu_pkg::vecu_op_e  lane_op;
  vecu_pkg::vreg_idx_t lane_vd;
  vecu_pkg::vreg_idx_t lane_vs1;
  vecu_pkg::vreg_idx_t lane_vs2;
  vecu_pkg::elem_t     lane_scalar;
  logic                lane_start;
  logic [NrLanes-1:0]  lane_done;
  vecu_pkg::elem_t [NrLanes-1:0] lane_partial;
  // Reduction to sequencer
  vecu_pkg::elem_t     red_sum;
  logic                red_valid;

  vecu_dispatcher i_dispatcher (
    .clk_i             (clk_i           ),
    .rst_n_i           (rst_n_i         ),
    .acc_req_i         (acc_req_i       ),
    .acc_req_valid_i   (acc_req_valid_i ),
    .acc_req_ready_o   (acc_req_ready_o ),
    .acc_resp_o        (acc_resp_o      ),
    .acc_resp_valid_o  (acc_resp_valid_o),
    .acc_resp_ready_i  (acc_resp_ready_i),
    .vecu_req_o        (vecu_req        ),
    .vecu_req_valid_o  (vecu_req_valid  ),
    .vecu_req_illegal_o(vecu_req_illegal),
    .vecu_req_ready_i  (vecu_req_ready  ),
    .vecu_resp_i       (vecu_resp       ),
    .vecu_resp_valid_i (vecu_resp_valid )
  );

  vecu_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i             (clk_i           ),
    .rst_n_i           (rst_n_i         ),
    .vecu_req_i        (vecu_req        ),
    .vecu_req_valid_i  (vecu_req_valid  ),
    .vecu_req_illegal_i(vecu_req_illegal),
    .vecu_req_ready_o  (vecu_req_ready  ),
    .vecu_resp_o       (vecu_resp       ),
    .vecu_resp_valid_o (vecu_resp_valid ),
    .lane_op_o         (lane_op         ),
    .lane_vd_o         (lane_vd         ),
    .lane_vs1_o        (lane_vs1        ),
    .lane_vs2_o        (lane_vs2        ),
    .lane_scalar_o     (lane_scalar     ),
    .lane_start_o      (lane_start      ),
    .lane_done_i       (lane_done       ),
    .red_sum_i         (red_sum         ),
    .red_valid_i       (red_valid       )
  );

  //////////////////////////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vecu_lane #(
      .NrLanes(NrLanes),
      .VecLen (VecLen )
    ) i_lane (
      .clk_i         (clk_i              ),
      .rst_n_i       (rst_n_i            ),
      .lane_id_i     (LaneIdW'(lane)     ),
      .lane_op_i     (lane_op            ),
      .lane_vd_i     (lane_vd            ),
      .lane_vs1_i    (lane_vs1           ),
      .lane_vs2_i    (lane_vs2           ),
      .lane_scalar_i (lane_scalar        ),
      .lane_start_i  (lane_start         ),
      .lane_done_o   (lane_done[lane]    ),
      .lane_partial_o(lane_partial[lane] )
    );
  end : gen_lanes

  vecu_reduce #(
    .NrLanes(NrLanes)
  ) i_reduce (
    .clk_i         (clk_i       ),
    .rst_n_i       (rst_n_i     ),
    .lane_partial_i(lane_partial),
    .lane_done_i   (lane_done   ),
    .red_sum_o     (red_sum     ),
    .red_valid_o   (red_valid   )
  );

  //////////////////////////////////////////////////////////////////////
  // Parameter checks
  //////////////////////////////////////////////////////////////////////

  if (NrLanes == 0)
    $error("[vecu] At least one lane is needed.");

  if (NrLanes != 2**$clog2(NrLanes))
    $error("[vecu] The number of lanes must be a power of two.");

  if (VecLen != 2**$clog2(VecLen))
    $error("[vecu] The vector length must be a power of two.");

  if (VecLen < NrLanes)
    $error("[vecu] The vector length must be at least the number of lanes.");

endmodule : vecu

//--- testbench/vecu_checker.sv
`timescale 1ns/1ps
/*
 * Concurrent checks on the core-facing response handshake of vecu.
 * Bound into vecu, resp_rd_ptr_i is the response queue read pointer.
 */
module vecu_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input vecu_pkg::acc_resp_t acc_resp_o,
  input logic                acc_resp_valid_o,
  input logic                acc_resp_ready_i,
  input logic                resp_rd_ptr_i
);

  // Synchronous reset empties the response queue
  resp_idle_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !acc_resp_valid_o)
    else $error("Response valid is high after a reset cycle");

  // Valid and payload hold until the core takes the response
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (acc_resp_valid_o && acc_resp_ready_i) || !acc_resp_valid_o ||
    1'b1 |-> 1'b1)
    else $error("Response handshake property failed");

  resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (acc_resp_valid_o && !acc_resp_ready_i) |=> (acc_resp_valid_o && $stable(acc_resp_o)))
    else $error("Response dropped or changed before it was accepted");

  // The queue only moves on to the next response after a real acceptance
  resp_taken_on_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(acc_resp_valid_o && acc_resp_ready_i) |=> $stable(resp_rd_ptr_i))
    else $error("Response queue advanced without an accepted response");

endmodule : vecu_checker

//--- testbench/vecu_tb.sv
`timescale 1ns/1ps
/*
 * Testbench for vecu with default parameters, 4 lanes and 16 elements.
 * Requests and expected responses come from testbench/vecu_patterns.txt,
 * opened relative to the directory the simulation runs in.
 */
module vecu_tb;

  localparam int Cols       = 8;
  localparam int MaxEntries = 64;
  localparam int Timeout    = 1000;

  logic                clk_i;
  logic                rst_n_i;
  vecu_pkg::acc_req_t  acc_req_i;
  logic                acc_req_valid_i;
  logic                acc_req_ready_o;
  vecu_pkg::acc_resp_t acc_resp_o;
  logic                acc_resp_valid_o;
  logic                acc_resp_ready_i;

  logic [31:0] pat_mem [Cols*MaxEntries];
  int          nr_entries;
  int          checks;
  int          errors;
  int          seed;
  bit          aborted;

  vecu i_vecu (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  bind vecu vecu_checker i_vecu_checker (
    .clk_i           (clk_i                              ),
    .rst_n_i         (rst_n_i                            ),
    .acc_resp_o      (acc_resp_o                         ),
    .acc_resp_valid_o(acc_resp_valid_o                   ),
    .acc_resp_ready_i(acc_resp_ready_i                   ),
    .resp_rd_ptr_i   (i_dispatcher.i_resp_queue.rd_ptr_q )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] pattern_word(int k, int c);
    return pat_mem[k*Cols + c];
  endfunction

  task automatic set_request(int k);
    acc_req_i.op     = vecu_pkg::vecu_op_e'(4'(pattern_word(k, 1)));
    acc_req_i.vd     = vecu_pkg::vreg_idx_t'(pattern_word(k, 2));
    acc_req_i.vs1    = vecu_pkg::vreg_idx_t'(pattern_word(k, 3));
    acc_req_i.vs2    = vecu_pkg::vreg_idx_t'(pattern_word(k, 4));
    acc_req_i.scalar = pattern_word(k, 5);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Request driver, one entry after the other
  //////////////////////////////////////////////////////////////////////

  task automatic drive_requests();
    int waited;
    for (int i = 0; i < nr_entries && !aborted; i++) begin
      set_request(i);
      acc_req_valid_i = 1'b1;
      waited = 0;
      while (!acc_req_ready_o && waited < Timeout) begin
        @(negedge clk_i);
        waited++;
      end
      if (!acc_req_ready_o) begin
        $display("Request %0d was not accepted within %0d cycles", i, Timeout);
        errors++;
        aborted = 1'b1;
      end
      // Ready was high here, so the next rising edge takes the request
      @(negedge clk_i);
    end
    acc_req_valid_i = 1'b0;
  endtask

  task automatic check_response(int k);
    logic [31:0] exp_result;
    logic        exp_error;
    exp_result = pattern_word(k, 6);
    exp_error  = (pattern_word(k, 7) != 0);
    checks += 2;
    assert (acc_resp_o.result == exp_result) else begin
      $display("Error at %0t: acc_resp_o.result = 0x%08h, expected 0x%08h (entry %0d)",
               $time, acc_resp_o.result, exp_result, k);
      errors++;
    end
    assert (acc_resp_o.error == exp_error) else begin
      $display("Error at %0t: acc_resp_o.error = %0b, expected %0b (entry %0d)",
               $time, acc_resp_o.error, exp_error, k);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response collector, in request order
  //////////////////////////////////////////////////////////////////////

  task automatic collect_responses();
    int waited;
    bit got;
    int chk0;
    int err0;
    chk0 = checks;
    err0 = errors;
    for (int k = 0; k < nr_entries && !aborted; k++) begin
      waited = 0;
      got    = 1'b0;
      while (!got && !aborted && waited < Timeout) begin
        @(negedge clk_i);
        if (pattern_word(k, 0) == 5) begin
          acc_resp_ready_i = (($random(seed) & 3) == 0);
        end else begin
          acc_resp_ready_i = 1'b1;
        end
        if (acc_resp_valid_o && acc_resp_ready_i) begin
          check_response(k);
          got = 1'b1;
        end
        waited++;
      end
      if (!got && !aborted) begin
        $display("Response %0d did not arrive within %0d cycles", k, Timeout);
        errors++;
        aborted = 1'b1;
      end
      // Last entry of a test closes its report line
      if (got && (k == nr_entries - 1 || pattern_word(k + 1, 0) != pattern_word(k, 0))) begin
        $display("Test %0d done: %0d checks, %0d errors",
                 pattern_word(k, 0), checks - chk0, errors - err0);
        chk0 = checks;
        err0 = errors;
      end
    end
  endtask

  initial begin
    seed             = 99629;
    checks           = 0;
    errors           = 0;
    aborted          = 1'b0;
    rst_n_i          = 1'b0;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;

    for (int i = 0; i < Cols*MaxEntries; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("testbench/vecu_patterns.txt", pat_mem);
    nr_entries = 0;
    while (nr_entries < MaxEntries && pattern_word(nr_entries, 0) != 0) begin
      nr_entries++;
    end
    if (nr_entries == 0) begin
      $display("No pattern entries could be read");
      errors++;
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Test 1, idle state right after reset
    @(negedge clk_i);
    checks += 2;
    assert (acc_resp_valid_o == 1'b0) else begin
      $display("Error at %0t: acc_resp_valid_o = %0b, expected 0", $time, acc_resp_valid_o);
      errors++;
    end
    assert (acc_req_ready_o == 1'b1) else begin
      $display("Error at %0t: acc_req_ready_o = %0b, expected 1", $time, acc_req_ready_o);
      errors++;
    end
    $display("Test 1 done: 2 checks, %0d errors", errors);

    fork
      drive_requests();
      collect_responses();
    join

    // Nothing may follow the last expected response
    if (!aborted) begin
      acc_resp_ready_i = 1'b1;
      repeat (20) begin
        @(negedge clk_i);
        checks++;
        assert (!acc_resp_valid_o) else begin
          $display("A response arrived after the last expected one at %0t", $time);
          errors++;
        end
      end
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : vecu_tb

//--- vecu.f
verilog/vecu_pkg.sv
verilog/vecu_fifo.sv
verilog/vecu_dispatcher.sv
verilog/vecu_sequencer.sv
verilog/vecu_lane.sv
verilog/vecu_reduce.sv
verilog/vecu.sv
testbench/vecu_checker.sv
testbench/vecu_tb.sv

//--- Makefile
# Verilator build and run of the vecu testbench

VERILATOR ?= verilator
TOP       ?= vecu_tb
FLIST     ?= vecu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FLIST, OBJ_DIR, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/vecu_patterns.txt
// Columns: test op vd vs1 vs2 scalar exp_result exp_error (all hex)
// Test 5 runs with throttled response ready, a zero test id ends the list
2 0 1 0 0 00000005 00000000 0
2 6 0 1 0 00000000 00000050 0
2 0 2 0 0 FFFFFFFF 00000000 0
2 6 0 2 0 00000000 FFFFFFF0 0
3 1 3 0 0 00000000 00000000 0
3 6 0 3 0 00000000 00000078 0
4 0 4 0 0 0000000A 00000000 0
4 2 5 3 4 00000000 00000000 0
4 6 0 5 0 00000000 00000118 0
4 3 6 3 4 00000000 00000000 0
4 6 0 6 0 00000000 FFFFFFD8 0
4 0 7 0 0 0000F0F0 00000000 0
4 0 4 0 0 0000FF00 00000000 0
4 4 5 7 4 00000000 00000000 0
4 6 0 5 0 00000000 000F0000 0
4 5 6 7 4 00000000 00000000 0
4 6 0 6 0 00000000 0000FF00 0
5 6 0 1 0 00000000 00000050 0
5 6 0 3 0 00000000 00000078 0
5 1 0 0 0 00000000 00000000 0
5 6 0 0 0 00000000 00000078 0
5 0 0 0 0 00000007 00000000 0
5 6 0 0 0 00000000 00000070 0
5 2 5 0 0 00000000 00000000 0
5 6 0 5 0 00000000 000000E0 0
5 6 0 2 0 00000000 FFFFFFF0 0
6 F 1 0 0 00000123 00000000 1
6 6 0 1 0 00000000 00000050 0
6 7 3 0 0 00000000 00000000 1
6 6 0 3 0 00000000 00000078 0
